// File: build.f
+incdir+sim
rtl/mdPkg.sv
rtl/operandPrep.sv
rtl/shiftAddMultiplier.sv
rtl/nonRestoringDivider.sv
rtl/resultFormat.sv
rtl/mdSequencer.sv
rtl/multDivUnit.sv
sim/multDivUnitTb.sv

// File: sim/mdRefModel.svh
`ifndef MD_REF_MODEL_SVH
`define MD_REF_MODEL_SVH

// operands widened by one bit so the unsigned forms stay positive
function automatic logic [XLen-1:0] refMultiply(input mdOp_t op, input logic [XLen-1:0] lOp,
                                                input logic [XLen-1:0] rOp);
  logic signed [2*XLen:0] a;
  logic signed [2*XLen:0] b;
  logic signed [2*XLen:0] p;
  a = (op == opMulh || op == opMulhsu) ? {{(XLen+1){lOp[XLen-1]}}, lOp}
                                       : {{(XLen+1){1'b0}}, lOp};
  b = (op == opMulh) ? {{(XLen+1){rOp[XLen-1]}}, rOp} : {{(XLen+1){1'b0}}, rOp};
  p = a * b;
  return (op == opMul) ? p[XLen-1:0] : p[2*XLen-1:XLen];
endfunction

// rOp is the dividend, lOp the divisor
function automatic mdResp_t refDivide(input mdOp_t op, input logic [XLen-1:0] lOp,
                                      input logic [XLen-1:0] rOp);
  mdResp_t                expected;
  logic signed [XLen-1:0] sl;
  logic signed [XLen-1:0] sr;
  logic                   isSigned;
  logic                   wantRem;
  sl       = lOp;
  sr       = rOp;
  isSigned = (op == opDiv) || (op == opRem);
  wantRem  = (op == opRem) || (op == opRemu);
  expected = '0;
  if (lOp == '0) begin
    expected.divByZero = 1'b1;
    expected.result    = wantRem ? rOp : {XLen{1'b1}};
  end else if (isSigned && lOp == '1 && rOp == {1'b1, {(XLen-1){1'b0}}}) begin
    expected.divOverflow = 1'b1;
    expected.result      = wantRem ? {XLen{1'b0}} : rOp;
  end else if (isSigned) begin
    // truncating division, remainder takes the dividend sign
    expected.result = wantRem ? sr % sl : sr / sl;
  end else begin
    expected.result = wantRem ? rOp % lOp : rOp / lOp;
  end
  return expected;
endfunction

function automatic mdResp_t refResponse(input mdOp_t op, input logic [XLen-1:0] lOp,
                                        input logic [XLen-1:0] rOp);
  mdResp_t expected;
  expected = '0;
  if (op[2]) begin
    expected = refDivide(op, lOp, rOp);
  end else begin
    expected.result = refMultiply(op, lOp, rOp);
  end
  return expected;
endfunction

`endif

// File: sim/multDivUnitTb.sv
`timescale 1ns/1ns
`default_nettype none

module multDivUnitTb;
  import mdPkg::*;

  `include "mdRefModel.svh"

  // 60 operations of about 40 cycles, plus the stall and credit waits
  localparam int NumOps        = 60;
  localparam int CyclesPerOp   = 40;
  localparam int StallBudget   = 1600;
  localparam int TimeoutCycles = NumOps * CyclesPerOp + StallBudget;

  logic    clk = 1'b0;
  logic    reset;
  mdReq_t  req;
  logic    reqValid;
  logic    reqCredit;
  mdResp_t resp;
  logic    respValid;
  logic    respCredit;

  int      seed;
  int      errorCount;
  int      testCount;
  int      failedTests;
  int      cycleCount;
  int      creditCount;
  int      issuedCount;
  int      grantedCount;
  int      respCount;
  string   testName;
  mdResp_t expQ[$];
  mdResp_t expHead;

  multDivUnit i_dut (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .reqValid   (reqValid),
    .reqCredit  (reqCredit),
    .resp       (resp),
    .respValid  (respValid),
    .respCredit (respCredit)
  );

  always #5 clk = ~clk;

  // handshake bookkeeping
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (reset) begin
      creditCount  <= 0;
      issuedCount  <= 0;
      grantedCount <= 0;
      respCount    <= 0;
    end else begin
      if (reqCredit) creditCount <= creditCount + 1;
      if (reqValid) issuedCount <= issuedCount + 1;
      if (respCredit) grantedCount <= grantedCount + 1;
      if (respValid) respCount <= respCount + 1;
    end
  end

  always @(posedge clk) begin
    if (cycleCount >= TimeoutCycles) begin
      $display("run stopped after %0d cycles without finishing", cycleCount);
      $display("TEST FAILED");
      $finish;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    respValid |-> (resp == expHead))
    else begin
      errorCount++;
      $display("MISMATCH %s expected %h actual %h", testName, expHead, resp);
    end

  // a response needs a granted credit and a pending request
  assert property (@(posedge clk) disable iff (reset)
    respValid |-> ((respCount < grantedCount) && (respCount < issuedCount)))
    else begin
      errorCount++;
      $display("response in %s without a credit or a pending request", testName);
    end

  // next request credit only once the previous response has left
  assert property (@(posedge clk) disable iff (reset)
    reqCredit |-> ((creditCount == issuedCount) && (respCount == issuedCount)))
    else begin
      errorCount++;
      $display("request credit in %s while a response is still owed", testName);
    end

  assert property (@(posedge clk) disable iff (reset)
    reqValid |-> (creditCount == issuedCount + 1))
    else begin
      errorCount++;
      $display("request in %s sent without exactly one credit in hand", testName);
    end

  assert property (@(posedge clk) reset |=> (!respValid && !reqCredit))
    else begin
      errorCount++;
      $display("respValid or reqCredit high during or right after reset");
    end

  task automatic grantCredit();
    respCredit = 1'b1;
    @(negedge clk);
    respCredit = 1'b0;
  endtask

  task automatic issueOp(input string name, input mdOp_t op, input logic [XLen-1:0] lOp,
                         input logic [XLen-1:0] rOp);
    mdResp_t expected;
    while (creditCount == issuedCount) @(negedge clk);
    testName = name;
    expected = refResponse(op, lOp, rOp);
    if (expQ.size() == 0) expHead = expected;
    expQ.push_back(expected);
    req      = '{op: op, lOp: lOp, rOp: rOp};
    reqValid = 1'b1;
    @(negedge clk);
    reqValid = 1'b0;
  endtask

  task automatic collectResp(input int errorsBefore);
    while (!respValid) @(negedge clk);
    // head stays put until the edge that checks it has passed
    @(negedge clk);
    void'(expQ.pop_front());
    if (expQ.size() != 0) expHead = expQ[0];
    testCount++;
    if (errorCount == errorsBefore) begin
      $display("test %s ok", testName);
    end else begin
      failedTests++;
      $display("test %s failed", testName);
    end
  endtask

  task automatic runOp(input string name, input mdOp_t op, input logic [XLen-1:0] lOp,
                       input logic [XLen-1:0] rOp, input logic grant);
    int errorsBefore;
    errorsBefore = errorCount;
    issueOp(name, op, lOp, rOp);
    if (grant) grantCredit();
    collectResp(errorsBefore);
  endtask

  initial begin
    int              errs;
    mdOp_t           op;
    logic [XLen-1:0] a;
    logic [XLen-1:0] b;
    seed       = 92;
    reset      = 1'b1;
    req        = '0;
    reqValid   = 1'b0;
    respCredit = 1'b0;
    expHead    = '0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    // idle gap so a second credit pulse would show up
    repeat (10) @(negedge clk);

    for (int k = 0; k < 4; k++) begin
      op = mdOp_t'(k);
      runOp($sformatf("%s min*min", op.name()), op, 32'h8000_0000, 32'h8000_0000, 1'b1);
      runOp($sformatf("%s -1*-1", op.name()), op, 32'hffff_ffff, 32'hffff_ffff, 1'b1);
      runOp($sformatf("%s max*-1", op.name()), op, 32'h7fff_ffff, 32'hffff_ffff, 1'b1);
      for (int n = 0; n < 3; n++) begin
        a = $random(seed);
        b = $random(seed);
        runOp($sformatf("%s random %0d", op.name(), n), op, a, b, 1'b1);
      end
    end

    for (int k = 4; k < 8; k++) begin
      op = mdOp_t'(k);
      runOp($sformatf("%s 20/-7", op.name()), op, -32'sd7, 32'sd20, 1'b1);
      runOp($sformatf("%s -20/7", op.name()), op, 32'sd7, -32'sd20, 1'b1);
      for (int n = 0; n < 3; n++) begin
        a = $random(seed) % 4096;
        b = $random(seed);
        runOp($sformatf("%s random %0d", op.name(), n), op, a, b, 1'b1);
      end
      runOp($sformatf("%s by zero", op.name()), op, 32'h0, 32'hdead_beef, 1'b1);
      // only the signed forms overflow
      runOp($sformatf("%s min/-1", op.name()), op, 32'hffff_ffff, 32'h8000_0000, 1'b1);
    end

    // finished response must wait for a credit
    errs = errorCount;
    issueOp("stalled response", opMulhu, 32'h1234_5678, 32'h9abc_def0);
    repeat (60) @(negedge clk);
    grantCredit();
    collectResp(errs);

    grantCredit();
    grantCredit();
    runOp("pre-granted first", opDiv, 32'h0000_0013, 32'hfff0_0001, 1'b0);
    runOp("pre-granted second", opRemu, 32'h0000_0013, 32'hfff0_0001, 1'b0);

    $display("tests run %0d, ok %0d, bad %0d, errors %0d",
             testCount, testCount - failedTests, failedTests, errorCount);
    if (errorCount == 0 && failedTests == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/multDivUnit.sv
`timescale 1ns/1ns
`default_nettype none

module multDivUnit (
  input  logic           clk,
  input  logic           reset,
  input  mdPkg::mdReq_t  req,
  input  logic           reqValid,
  output logic           reqCredit,
  output mdPkg::mdResp_t resp,
  output logic           respValid,
  input  logic           respCredit
);
  import mdPkg::*;

  mdReq_t            heldReq;
  mdOperands_t       ops;
  mdResp_t           formatted;
  logic              startMul;
  logic              startDiv;
  logic              mulDone;
  logic              divDone;
  logic [2*XLen-1:0] product;
  logic [XLen-1:0]   quotient;
  logic [XLen-1:0]   remainder;

  mdSequencer i_sequencer (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .reqValid   (reqValid),
    .reqCredit  (reqCredit),
    .respCredit (respCredit),
    .respValid  (respValid),
    .resp       (resp),
    .heldReq    (heldReq),
    .startMul   (startMul),
    .startDiv   (startDiv),
    .mulDone    (mulDone),
    .divDone    (divDone),
    .formatted  (formatted)
  );

  operandPrep i_operandPrep (
    .req (heldReq),
    .ops (ops)
  );

  // lOp drives multiplicand and divisor, rOp multiplier and dividend
  shiftAddMultiplier i_multiplier (
    .clk          (clk),
    .reset        (reset),
    .startMul     (startMul),
    .multiplicand (ops.magL),
    .multiplier   (ops.magR),
    .done         (mulDone),
    .product      (product)
  );

  nonRestoringDivider i_divider (
    .clk       (clk),
    .reset     (reset),
    .startDiv  (startDiv),
    .dividend  (ops.magR),
    .divisor   (ops.magL),
    .done      (divDone),
    .quotient  (quotient),
    .remainder (remainder)
  );

  resultFormat i_resultFormat (
    .ops       (ops),
    .product   (product),
    .quotient  (quotient),
    .remainder (remainder),
    .resp      (formatted)
  );

endmodule

`default_nettype wire

// File: rtl/mdSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module mdSequencer (
  input  logic           clk,
  input  logic           reset,
  input  mdPkg::mdReq_t  req,
  input  logic           reqValid,
  output logic           reqCredit,
  input  logic           respCredit,
  output logic           respValid,
  output mdPkg::mdResp_t resp,
  output mdPkg::mdReq_t  heldReq,
  output logic           startMul,
  output logic           startDiv,
  input  logic           mulDone,
  input  logic           divDone,
  input  mdPkg::mdResp_t formatted
);
  import mdPkg::*;

  typedef enum logic [1:0] {
    idle,
    busy,
    holding,
    sending
  } seqState_t;

  seqState_t                           state;
  logic [$clog2(MaxRespCredits+1)-1:0] respCredits;
  logic [$clog2(ReqCredits+1)-1:0]     reqCreditsOut;
  logic                                accept;
  logic                                engineDone;
  logic                                grantReq;
  logic                                spendResp;

  assign accept     = (state == idle) && reqValid;
  assign engineDone = (state == busy) && (mulDone || divDone);
  assign spendResp  = (state == holding) && (respCredits != '0);

  // next credit goes out in the cycle after the response leaves
  assign grantReq = ((state == idle) || (state == sending)) && (reqCreditsOut < ReqCredits);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      startMul  <= 1'b0;
      startDiv  <= 1'b0;
      respValid <= 1'b0;
      reqCredit <= 1'b0;
    end else begin
      startMul  <= 1'b0;
      startDiv  <= 1'b0;
      respValid <= 1'b0;
      reqCredit <= grantReq;
      case (state)
        idle: begin
          if (accept) begin
            state    <= busy;
            startDiv <= req.op[2];
            startMul <= !req.op[2];
          end
        end
        busy: begin
          if (engineDone) state <= holding;
        end
        holding: begin
          if (spendResp) begin
            respValid <= 1'b1;
            state     <= sending;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // outstanding request credits and saturating response credits
  always_ff @(posedge clk) begin
    if (reset) begin
      reqCreditsOut <= '0;
      respCredits   <= '0;
    end else begin
      if (grantReq && !accept) begin
        reqCreditsOut <= reqCreditsOut + 1'b1;
      end else if (accept && !grantReq) begin
        reqCreditsOut <= reqCreditsOut - 1'b1;
      end
      if (respCredit && !spendResp && (respCredits < MaxRespCredits)) begin
        respCredits <= respCredits + 1'b1;
      end else if (spendResp && !respCredit) begin
        respCredits <= respCredits - 1'b1;
      end
    end
  end

  // request and response registers
  always_ff @(posedge clk) begin
    if (accept) heldReq <= req;
    if (engineDone) resp <= formatted;
  end

  assert property (@(posedge clk) disable iff (reset)
    reqValid |-> (reqCreditsOut != '0))
    else $error("mdSequencer: reqValid without a request credit");

  // each response takes exactly one held credit
  assert property (@(posedge clk) disable iff (reset)
    respValid |-> ($past(respCredits) != '0) &&
                  (respCredits == $past(respCredits) - 1'b1 + $past(respCredit)))
    else $error("mdSequencer: respValid without spending a response credit");

endmodule

`default_nettype wire

// File: rtl/resultFormat.sv
`timescale 1ns/1ns
`default_nettype none

module resultFormat (
  input  mdPkg::mdOperands_t         ops,
  input  logic [2*mdPkg::XLen-1:0]   product,
  input  logic [mdPkg::XLen-1:0]     quotient,
  input  logic [mdPkg::XLen-1:0]     remainder,
  output mdPkg::mdResp_t             resp
);
  import mdPkg::*;

  logic [2*XLen-1:0] signedProd;
  logic [XLen-1:0]   signedQuot;
  logic [XLen-1:0]   signedRem;
  logic [XLen-1:0]   dividendVal;
  logic [XLen-1:0]   result;

  assign signedProd = ops.negResult ? -product : product;
  assign signedQuot = ops.negResult ? -quotient : quotient;
  assign signedRem  = ops.negRem ? -remainder : remainder;

  // dividend rebuilt from its magnitude for the divide-by-zero remainder
  assign dividendVal = ops.negRem ? -ops.magR : ops.magR;

  always_comb begin
    case (ops.op)
      opMul: begin
        result = signedProd[XLen-1:0];
      end
      opMulh, opMulhsu, opMulhu: begin
        result = signedProd[2*XLen-1:XLen];
      end
      opDiv, opDivu: begin
        result = signedQuot;
      end
      default: begin
        result = signedRem;
      end
    endcase
    // op bit 1 picks the remainder within the divide family
    if (ops.divByZero) begin
      result = ops.op[1] ? dividendVal : {XLen{1'b1}};
    end else if (ops.divOverflow) begin
      result = ops.op[1] ? {XLen{1'b0}} : {1'b1, {(XLen-1){1'b0}}};
    end
  end

  assign resp = '{result:      result,
                  divByZero:   ops.divByZero,
                  divOverflow: ops.divOverflow};

endmodule

`default_nettype wire

// File: rtl/nonRestoringDivider.sv
`timescale 1ns/1ns
`default_nettype none

module nonRestoringDivider (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   startDiv,
  input  logic [mdPkg::XLen-1:0] dividend,
  input  logic [mdPkg::XLen-1:0] divisor,
  output logic                   done,
  output logic [mdPkg::XLen-1:0] quotient,
  output logic [mdPkg::XLen-1:0] remainder
);
  import mdPkg::*;

  logic [CountWidth-1:0] count;
  logic [XLen-1:0]       divisorReg;
  logic [XLen:0]         partRem;
  logic [XLen-1:0]       quotReg;
  logic [XLen:0]         shifted;
  logic [XLen:0]         nextRem;
  logic                  iterate;
  logic                  correct;

  // count runs XLen+1 down to 1 and the last step corrects
  assign iterate = (count > CountWidth'(1));
  assign correct = (count == CountWidth'(1));

  // next dividend bit enters from the quotient register
  assign shifted = {partRem[XLen-1:0], quotReg[XLen-1]};

  // subtract while the remainder is non-negative, add back otherwise
  assign nextRem = partRem[XLen] ? shifted + {1'b0, divisorReg}
                                 : shifted - {1'b0, divisorReg};

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (startDiv) begin
        count <= CountWidth'(XLen + 1);
      end else if (count != '0) begin
        count <= count - 1'b1;
        done  <= correct;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (startDiv) begin
      divisorReg <= divisor;
      partRem    <= '0;
      quotReg    <= dividend;
    end else if (iterate) begin
      partRem <= nextRem;
      // quotient bit is set when the new remainder stays non-negative
      quotReg <= {quotReg[XLen-2:0], ~nextRem[XLen]};
    end else if (correct && partRem[XLen]) begin
      partRem <= partRem + {1'b0, divisorReg};
    end
  end

  assign quotient  = quotReg;
  assign remainder = partRem[XLen-1:0];

  // load, XLen steps and the correction, then a single done cycle
  assert property (@(posedge clk) disable iff (reset)
    startDiv |-> ##(XLen + 2) (done ##1 !done))
    else $error("nonRestoringDivider: done not a single cycle 34 cycles after start");

endmodule

`default_nettype wire

// File: rtl/shiftAddMultiplier.sv
`timescale 1ns/1ns
`default_nettype none

module shiftAddMultiplier (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     startMul,
  input  logic [mdPkg::XLen-1:0]   multiplicand,
  input  logic [mdPkg::XLen-1:0]   multiplier,
  output logic                     done,
  output logic [2*mdPkg::XLen-1:0] product
);
  import mdPkg::*;

  logic [CountWidth-1:0] count;
  logic [XLen-1:0]       mcand;
  logic [2*XLen-1:0]     prodReg;
  logic [XLen:0]         partialSum;

  // upper half plus multiplicand when the current multiplier bit is set
  assign partialSum = {1'b0, prodReg[2*XLen-1:XLen]} +
                      (prodReg[0] ? {1'b0, mcand} : {(XLen+1){1'b0}});

  // iteration counter, nonzero while busy
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (startMul) begin
        count <= CountWidth'(XLen);
      end else if (count != '0) begin
        count <= count - 1'b1;
        done  <= (count == CountWidth'(1));
      end
    end
  end

  // low half starts as the multiplier and is shifted out bit by bit
  always_ff @(posedge clk) begin
    if (startMul) begin
      mcand   <= multiplicand;
      prodReg <= {{XLen{1'b0}}, multiplier};
    end else if (count != '0) begin
      prodReg <= {partialSum, prodReg[XLen-1:1]};
    end
  end

  assign product = prodReg;

  // sequencer must wait for done before the next start
  assert property (@(posedge clk) disable iff (reset)
    startMul |-> (count == '0))
    else $error("shiftAddMultiplier: startMul while busy");

endmodule

`default_nettype wire

// File: rtl/operandPrep.sv
`timescale 1ns/1ns
`default_nettype none

module operandPrep (
  input  mdPkg::mdReq_t      req,
  output mdPkg::mdOperands_t ops
);
  import mdPkg::*;

  logic            signedL;
  logic            signedR;
  logic            negL;
  logic            negR;
  logic [XLen-1:0] magL;
  logic [XLen-1:0] magR;
  logic            divByZero;
  logic            divOverflow;

  // signedness per opcode, MUL low half is the same either way
  always_comb begin
    case (req.op)
      opMulh, opDiv, opRem: begin
        signedL = 1'b1;
        signedR = 1'b1;
      end
      opMulhsu: begin
        signedL = 1'b1;
        signedR = 1'b0;
      end
      default: begin
        signedL = 1'b0;
        signedR = 1'b0;
      end
    endcase
  end

  assign negL = signedL & req.lOp[XLen-1];
  assign negR = signedR & req.rOp[XLen-1];

  // most negative value maps onto 2^(XLen-1), still fits unsigned
  assign magL = negL ? -req.lOp : req.lOp;
  assign magR = negR ? -req.rOp : req.rOp;

  assign divByZero   = req.op[2] && (req.lOp == '0);
  assign divOverflow = req.op[2] && signedR && (req.lOp == '1) &&
                       (req.rOp == {1'b1, {(XLen-1){1'b0}}});

  // remainder follows the dividend sign
  assign ops = '{op:          req.op,
                 magL:        magL,
                 magR:        magR,
                 negResult:   negL ^ negR,
                 negRem:      negR,
                 divByZero:   divByZero,
                 divOverflow: divOverflow};

endmodule

`default_nettype wire

// File: rtl/mdPkg.sv
`default_nettype none

package mdPkg;

  localparam int XLen           = 32;
  localparam int CountWidth     = 6;
  localparam int MaxRespCredits = 2;
  localparam int ReqCredits     = 1;

  // bit 2 set for the divide family
  typedef enum logic [2:0] {
    opMul    = 3'b000,
    opMulh   = 3'b001,
    opMulhsu = 3'b010,
    opMulhu  = 3'b011,
    opDiv    = 3'b100,
    opDivu   = 3'b101,
    opRem    = 3'b110,
    opRemu   = 3'b111
  } mdOp_t;

  // lOp is the divisor, rOp the dividend
  typedef struct packed {
    mdOp_t           op;
    logic [XLen-1:0] lOp;
    logic [XLen-1:0] rOp;
  } mdReq_t;

  typedef struct packed {
    mdOp_t           op;
    logic [XLen-1:0] magL;
    logic [XLen-1:0] magR;
    logic            negResult;
    logic            negRem;
    logic            divByZero;
    logic            divOverflow;
  } mdOperands_t;

  typedef struct packed {
    logic [XLen-1:0] result;
    logic            divByZero;
    logic            divOverflow;
  } mdResp_t;

endpackage

`default_nettype wire
